//--- cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// geometry
`define CACHE_SETS      256
`define CACHE_INDEX_W   8
`define CACHE_TAG_W     20
`define CACHE_OFFSET_W  4

// word and bank layout
`define CACHE_WORD_W    32
`define CACHE_BANKS     4
`define CACHE_STRB_W    4

// line read code on rd_type
`define CACHE_RD_TYPE   3'b100

`endif

//--- cache_req_pkg.sv
`default_nettype none
`include "cache_cfg.svh"

package cache_req_pkg;

	typedef logic [`CACHE_TAG_W-1:0]   tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_WORD_W-1:0]  word_t;
	typedef logic [`CACHE_STRB_W-1:0]  strb_t;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} op_t;

	// processor request, 69 bits
	typedef struct packed {
		op_t                         op;
		index_t                      index;
		tag_t                        tag;
		logic [`CACHE_OFFSET_W-1:0]  offset;
		strb_t                       wstrb;
		word_t                       wdata;
	} cache_req_t;

	// line read address, offset always zero
	typedef struct packed {
		tag_t                        tag;
		index_t                      index;
		logic [`CACHE_OFFSET_W-1:0]  offset;
	} mem_rd_t;

endpackage

`default_nettype wire

//--- cache_store_pkg.sv
`default_nettype none
`include "cache_cfg.svh"

package cache_store_pkg;

	typedef enum logic [3:0] {
		S_IDLE    = 4'b0001,
		S_LOOKUP  = 4'b0010,
		S_REPLACE = 4'b0100,
		S_REFILL  = 4'b1000
	} ctrl_state_t;

	typedef logic way_t;
	typedef logic [$clog2(`CACHE_BANKS)-1:0] bank_t;

	typedef struct packed {
		logic [`CACHE_INDEX_W-1:0] index;
		way_t                      way;
		bank_t                     bank;
		logic [`CACHE_WORD_W-1:0]  word;
	} wbuf_entry_t;

	typedef struct packed {
		logic                      strobe;
		bank_t                     bank;
		logic [`CACHE_WORD_W-1:0]  word;
		logic                      last;
	} refill_beat_t;

	// byte-wise overlay of new_word onto old_word
	function automatic logic [`CACHE_WORD_W-1:0] merge_word(
		input logic [`CACHE_WORD_W-1:0] old_word,
		input logic [`CACHE_WORD_W-1:0] new_word,
		input logic [`CACHE_STRB_W-1:0] strb
	);
		logic [`CACHE_WORD_W-1:0] res;
		res = old_word;
		for (int i = 0; i < `CACHE_STRB_W; i++) begin
			if (strb[i])
				res[i*8 +: 8] = new_word[i*8 +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

//--- cache_sram.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module cache_sram #(
	parameter type entry_t = logic [31:0]
) (
	input  logic                      clk_g,
	input  logic                      en,
	input  logic                      we,
	input  logic [`CACHE_INDEX_W-1:0] addr,
	input  entry_t                    wdata,
	output entry_t                    rdata
);

	entry_t mem [`CACHE_SETS];

	// read-first, output held while en is low
	always_ff @(posedge clk_g) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- cache_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl_fsm
	import cache_store_pkg::*;
(
	input  logic        clk_g,
	input  logic        resetn,
	input  logic        valid,
	input  logic        hit,
	input  logic        wbuf_busy,
	input  logic        rd_rdy,
	input  logic        refill_done,
	output ctrl_state_t state,
	output logic        addr_ok,
	output logic        rd_req,
	output logic        data_ok,
	output logic        data_from_refill
);

	ctrl_state_t state_nxt;
	logic        done_q;

	always_ff @(posedge clk_g) begin
		if (!resetn) begin
			state <= S_IDLE;
			done_q <= 1'b0;
		end else begin
			state <= state_nxt;
			done_q <= refill_done && state == S_REFILL;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (valid && addr_ok)
					state_nxt = S_LOOKUP;
			end
			S_LOOKUP: begin
				state_nxt = hit ? S_IDLE : S_REPLACE;
			end
			S_REPLACE: begin
				if (rd_rdy)
					state_nxt = S_REFILL;
			end
			S_REFILL: begin
				if (refill_done)
					state_nxt = S_IDLE;
			end
			default: begin
				state_nxt = S_IDLE;
			end
		endcase
	end

	// pending store write blocks the bank ports
	assign addr_ok = valid && state == S_IDLE && !wbuf_busy;
	assign rd_req = state == S_REPLACE;

	// hit answers in lookup and a miss the cycle after the last beat
	assign data_ok = (state == S_LOOKUP && hit) || done_q;
	assign data_from_refill = done_q;

endmodule

`default_nettype wire

//--- refill_counter.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module refill_counter
	import cache_req_pkg::*, cache_store_pkg::*;
(
	input  logic         clk_g,
	input  logic         resetn,
	input  logic         ret_valid,
	input  logic         ret_last,
	input  word_t        ret_data,
	input  cache_req_t   req_r,
	output refill_beat_t beat,
	output logic         refill_done,
	output word_t        miss_word
);

	bank_t cnt;
	bank_t req_bank;
	logic  at_req_bank;

	always_ff @(posedge clk_g) begin
		if (!resetn)
			cnt <= '0;
		else if (ret_valid && ret_last)
			cnt <= '0;
		else if (ret_valid)
			cnt <= cnt + 1'b1;
	end

	assign req_bank = req_r.offset[`CACHE_OFFSET_W-1:2];
	assign at_req_bank = cnt == req_bank;

	assign beat.strobe = ret_valid;
	assign beat.bank = cnt;
	assign beat.last = ret_last;
	// store miss lands its bytes in the matching beat
	assign beat.word = (at_req_bank && req_r.op == OP_WRITE)
		? merge_word(ret_data, req_r.wdata, req_r.wstrb) : ret_data;

	assign refill_done = ret_valid && ret_last;

	always_ff @(posedge clk_g) begin
		if (ret_valid && at_req_bank)
			miss_word <= beat.word;
	end

endmodule

`default_nettype wire

//--- cache_datapath.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module cache_datapath
	import cache_req_pkg::*, cache_store_pkg::*;
(
	input  logic         clk_g,
	input  logic         resetn,
	input  logic         valid,
	input  cache_req_t   req,
	input  ctrl_state_t  state,
	input  refill_beat_t beat,
	output logic         hit,
	output logic         wbuf_busy,
	output word_t        load_word,
	output cache_req_t   req_r,
	output mem_rd_t      rd_addr
);

	logic                        accept;
	logic                        lookup;
	logic                        refill_wr;
	logic                        store_hit;
	logic                        wbuf_pending;
	wbuf_entry_t                 wbuf_q;
	way_t                        victim_q;
	logic [1:0][`CACHE_SETS-1:0] valid_q;
	logic [1:0]                  way_hit;
	bank_t                       req_bank;
	index_t                      ram_addr;
	tag_t                        tag_rd [2];
	word_t                       word_rd [2][`CACHE_BANKS];

	assign accept = valid && state == S_IDLE && !wbuf_pending;
	assign lookup = state == S_LOOKUP;
	assign refill_wr = state == S_REFILL && beat.strobe;
	assign req_bank = req_r.offset[`CACHE_OFFSET_W-1:2];

	// incoming index on acceptance, else whoever is writing
	assign ram_addr = accept ? req.index : (wbuf_pending ? wbuf_q.index : req_r.index);

	always_ff @(posedge clk_g) begin
		if (accept)
			req_r <= req;
	end

	for (genvar w = 0; w < 2; w++) begin : g_way
		logic tag_we;
		assign tag_we = refill_wr && beat.last && victim_q == way_t'(w);
		assign way_hit[w] = valid_q[w][req_r.index] && tag_rd[w] == req_r.tag;

		cache_sram #(.entry_t(tag_t)) u_tag (
			.clk_g(clk_g),
			.en(accept || tag_we),
			.we(tag_we),
			.addr(ram_addr),
			.wdata(req_r.tag),
			.rdata(tag_rd[w])
		);

		for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
			logic wr;
			assign wr = (wbuf_pending && wbuf_q.way == way_t'(w) && wbuf_q.bank == bank_t'(b))
				|| (refill_wr && victim_q == way_t'(w) && beat.bank == bank_t'(b));

			cache_sram #(.entry_t(word_t)) u_bank (
				.clk_g(clk_g),
				.en(accept || wr),
				.we(wr),
				.addr(ram_addr),
				.wdata(wbuf_pending ? wbuf_q.word : beat.word),
				.rdata(word_rd[w][b])
			);
		end
	end

	assign hit = lookup && (|way_hit);
	assign load_word = way_hit[1] ? word_rd[1][req_bank] : word_rd[0][req_bank];
	assign store_hit = hit && req_r.op == OP_WRITE;
	assign wbuf_busy = wbuf_pending;

	always_ff @(posedge clk_g) begin
		if (!resetn) begin
			wbuf_pending <= 1'b0;
			valid_q <= '0;
		end else begin
			wbuf_pending <= store_hit;
			if (refill_wr && beat.last)
				valid_q[victim_q][req_r.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk_g) begin
		if (store_hit) begin
			wbuf_q.index <= req_r.index;
			wbuf_q.way <= way_hit[1];
			wbuf_q.bank <= req_bank;
			wbuf_q.word <= merge_word(load_word, req_r.wdata, req_r.wstrb);
		end
		// free way 0 first, otherwise way 1
		if (lookup)
			victim_q <= way_t'(valid_q[0][req_r.index]);
	end

	assign rd_addr.tag = req_r.tag;
	assign rd_addr.index = req_r.index;
	assign rd_addr.offset = '0;

endmodule

`default_nettype wire

//--- cache_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module cache_top
	import cache_req_pkg::*, cache_store_pkg::*;
(
	input  logic       clk_g,
	input  logic       resetn,
	input  logic       valid,
	input  cache_req_t req,
	output logic       addr_ok,
	output logic       data_ok,
	output word_t      rdata,
	output logic       rd_req,
	output logic [2:0] rd_type,
	output mem_rd_t    rd_addr,
	input  logic       rd_rdy,
	input  logic       ret_valid,
	input  logic       ret_last,
	input  word_t      ret_data
);

	ctrl_state_t  state;
	refill_beat_t beat;
	cache_req_t   req_r;
	word_t        load_word;
	word_t        miss_word;
	logic         hit;
	logic         wbuf_busy;
	logic         refill_done;
	logic         data_from_refill;

	cache_ctrl_fsm u_fsm (
		.clk_g(clk_g),
		.resetn(resetn),
		.valid(valid),
		.hit(hit),
		.wbuf_busy(wbuf_busy),
		.rd_rdy(rd_rdy),
		.refill_done(refill_done),
		.state(state),
		.addr_ok(addr_ok),
		.rd_req(rd_req),
		.data_ok(data_ok),
		.data_from_refill(data_from_refill)
	);

	refill_counter u_cnt (
		.clk_g(clk_g),
		.resetn(resetn),
		.ret_valid(ret_valid),
		.ret_last(ret_last),
		.ret_data(ret_data),
		.req_r(req_r),
		.beat(beat),
		.refill_done(refill_done),
		.miss_word(miss_word)
	);

	cache_datapath u_dp (
		.clk_g(clk_g),
		.resetn(resetn),
		.valid(valid),
		.req(req),
		.state(state),
		.beat(beat),
		.hit(hit),
		.wbuf_busy(wbuf_busy),
		.load_word(load_word),
		.req_r(req_r),
		.rd_addr(rd_addr)
	);

	assign rdata = data_from_refill ? miss_word : load_word;
	assign rd_type = `CACHE_RD_TYPE;

endmodule

`default_nettype wire

//--- cache_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module cache_checker
	import cache_req_pkg::*;
(
	input  logic       clk_g,
	input  logic       resetn,
	input  logic       valid,
	input  cache_req_t req,
	input  logic       addr_ok,
	input  logic       data_ok,
	input  word_t      rdata,
	input  logic       rd_req,
	input  logic [2:0] rd_type,
	input  mem_rd_t    rd_addr,
	input  logic       rd_rdy,
	output int         err_cnt,
	output int         done_cnt,
	output int         miss_cnt
);

	// reference copy of the cache contents
	logic       vld [2][`CACHE_SETS];
	tag_t       tags [2][`CACHE_SETS];
	word_t      words [2][`CACHE_SETS][`CACHE_BANKS];
	cache_req_t cur;
	word_t      exp_word;
	logic       busy;
	logic       first;
	logic       exp_hit;
	logic       saw_rd;
	logic       hold_req;

	function automatic word_t line_word(logic [31:0] line_addr, logic [1:0] bank);
		return {line_addr[31:4], bank, 2'b00} ^ 32'h5a5a_0000;
	endfunction

	function automatic word_t overlay_bytes(word_t old_word, word_t new_word, strb_t strb);
		word_t mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	task automatic check_word(string name, word_t exp, word_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic note_failure(string what);
		$display("%0t ns: %s", $time, what);
		err_cnt++;
	endtask

	task automatic accept_request();
		logic [1:0] bank;
		logic       way;
		logic [2:0] b;
		cur = req;
		bank = req.offset[3:2];
		exp_hit = 1'b1;
		if (vld[0][req.index] && tags[0][req.index] == req.tag)
			way = 1'b0;
		else if (vld[1][req.index] && tags[1][req.index] == req.tag)
			way = 1'b1;
		else begin
			// refill lands in way 0 while it is free
			exp_hit = 1'b0;
			way = vld[0][req.index];
			for (b = 3'd0; b < 3'd4; b++)
				words[way][req.index][b[1:0]] = line_word({req.tag, req.index, 4'h0}, b[1:0]);
			tags[way][req.index] = req.tag;
			vld[way][req.index] = 1'b1;
			miss_cnt++;
		end
		if (req.op == OP_WRITE)
			words[way][req.index][bank] =
				overlay_bytes(words[way][req.index][bank], req.wdata, req.wstrb);
		exp_word = words[way][req.index][bank];
	endtask

	always @(negedge clk_g) begin
		if (!resetn) begin
			vld = '{default: 1'b0};
			busy = 1'b0;
			first = 1'b0;
			saw_rd = 1'b0;
			hold_req = 1'b0;
		end else begin
			if (hold_req && !rd_req)
				note_failure("rd_req dropped before rd_rdy was seen");
			hold_req = rd_req && !rd_rdy;
			if (busy) begin
				if (addr_ok && !data_ok)
					note_failure("addr_ok high while a request is outstanding");
				if (rd_req) begin
					saw_rd = 1'b1;
					check_word("rd_addr", {cur.tag, cur.index, 4'h0}, rd_addr);
					if (rd_type != 3'd4)
						note_failure("rd_type is not the line read code");
				end
				if (first) begin
					first = 1'b0;
					if (exp_hit && !data_ok)
						note_failure("expected hit gave no data_ok in the lookup cycle");
					else if (!exp_hit && data_ok)
						note_failure("expected miss gave data_ok in the lookup cycle");
				end else if (data_ok && !saw_rd)
					note_failure("miss finished without a line read request");
				if (data_ok) begin
					if (cur.op == OP_READ)
						check_word("load", exp_word, rdata);
					else if (!exp_hit)
						check_word("store_miss", exp_word, rdata);
					busy = 1'b0;
					done_cnt++;
				end
			end else begin
				if (data_ok)
					note_failure("data_ok with no request outstanding");
				if (rd_req)
					note_failure("rd_req with no request outstanding");
				if (addr_ok && !valid)
					note_failure("addr_ok high with no valid request");
			end
			if (!busy && valid && addr_ok) begin
				accept_request();
				busy = 1'b1;
				first = 1'b1;
				saw_rd = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_cache.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module tb_cache
	import cache_req_pkg::*;
();

	localparam int N_REQ = 600;
	localparam int RESET_CYC = 16;
	localparam int WATCHDOG_CYC = N_REQ * 30 + RESET_CYC;

	logic       clk_g;
	logic       resetn;
	logic       valid;
	cache_req_t req;
	logic       addr_ok;
	logic       data_ok;
	word_t      rdata;
	logic       rd_req;
	logic [2:0] rd_type;
	mem_rd_t    rd_addr;
	logic       rd_rdy;
	logic       ret_valid;
	logic       ret_last;
	word_t      ret_data;
	integer     seed;
	int         err_cnt;
	int         done_cnt;
	int         miss_cnt;

	function automatic word_t mem_word(logic [31:0] line_addr, logic [1:0] bank);
		return {line_addr[31:4], bank, 2'b00} ^ 32'h5a5a_0000;
	endfunction

	function automatic index_t pick_index(logic sel);
		return sel ? 8'hc5 : 8'h3a;
	endfunction

	// three tags per set force evictions
	function automatic tag_t pick_tag(logic [1:0] sel);
		case (sel)
			2'd0: return 20'h0_1234;
			2'd1: return 20'h8_0abc;
			default: return 20'hf_ff00;
		endcase
	endfunction

	cache_top UUT (
		.clk_g(clk_g), .resetn(resetn), .valid(valid), .req(req),
		.addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
		.rd_req(rd_req), .rd_type(rd_type), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
		.ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data)
	);

	cache_checker u_check (
		.clk_g(clk_g), .resetn(resetn), .valid(valid), .req(req),
		.addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
		.rd_req(rd_req), .rd_type(rd_type), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
		.err_cnt(err_cnt), .done_cnt(done_cnt), .miss_cnt(miss_cnt)
	);

	initial begin
		clk_g = 1'b0;
		forever #20 clk_g = ~clk_g;
	end

	// request driver
	initial begin
		cache_req_t r;
		seed = 32'h1fb5_3775;
		resetn = 1'b0;
		valid = 1'b0;
		req = '0;
		repeat (RESET_CYC) @(posedge clk_g);
		#2;
		resetn = 1'b1;
		for (int n = 0; n < N_REQ; n++) begin
			repeat ({$random(seed)} % 2) begin
				@(posedge clk_g);
				#2;
			end
			r.op = ($random(seed) & 1) ? OP_WRITE : OP_READ;
			r.index = pick_index(1'($random(seed)));
			r.tag = pick_tag(2'({$random(seed)} % 3));
			r.offset = {2'($random(seed)), 2'b00};
			r.wstrb = 4'($random(seed));
			r.wdata = $random(seed);
			valid = 1'b1;
			req = r;
			@(negedge clk_g);
			while (!addr_ok)
				@(negedge clk_g);
			@(posedge clk_g);
			#2;
			valid = 1'b0;
		end
		wait (done_cnt == N_REQ);
		repeat (2) @(posedge clk_g);
		$display("requests %0d, misses %0d, errors %0d", done_cnt, miss_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// memory side with line read stalls and beat gaps
	initial begin
		logic [31:0] line_addr;
		rd_rdy = 1'b0;
		ret_valid = 1'b0;
		ret_last = 1'b0;
		ret_data = '0;
		forever begin
			@(posedge clk_g);
			#2;
			if (rd_req) begin
				line_addr = rd_addr;
				repeat ({$random(seed)} % 4) begin
					@(posedge clk_g);
					#2;
				end
				rd_rdy = 1'b1;
				@(posedge clk_g);
				#2;
				rd_rdy = 1'b0;
				for (int b = 0; b < 4; b++) begin
					ret_valid = 1'b0;
					repeat ({$random(seed)} % 3) begin
						@(posedge clk_g);
						#2;
					end
					ret_valid = 1'b1;
					ret_last = (b == 3);
					ret_data = mem_word(line_addr, 2'(b));
					@(posedge clk_g);
					#2;
				end
				ret_valid = 1'b0;
				ret_last = 1'b0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk_g);
		$display("watchdog expired with %0d of %0d requests done", done_cnt, N_REQ);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
cache_req_pkg.sv
cache_store_pkg.sv
cache_sram.sv
cache_ctrl_fsm.sv
refill_counter.sv
cache_datapath.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

//--- run_sim.sh
#!/bin/bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_cache -f verilog.f -o tb_cache \
	&& ./obj_dir/tb_cache > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; exit 1; }
grep -qx "TEST OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
